/* core_pkg.sv */
package core_pkg;

	// ****************************************
	// Widths and sizes
	// ****************************************

	localparam int DATA_WIDTH     = 32;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int CSR_ADDR_WIDTH = 2;
	localparam int NUM_REGS       = 1 << REG_ADDR_WIDTH;
	localparam int NUM_CSRS       = 1 << CSR_ADDR_WIDTH;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_LUI,   // Result is the pre-shifted immediate.
		OP_CSRRW  // Result is the old CSR value, rs1 goes into the CSR.
	} op_t;

	// ****************************************
	// Pipeline records
	// ****************************************

	typedef struct packed {
		op_t                       op;
		logic [REG_ADDR_WIDTH-1:0] rs1;
		logic [REG_ADDR_WIDTH-1:0] rs2;
		logic [REG_ADDR_WIDTH-1:0] rd;
		logic                      write_reg;
		logic [DATA_WIDTH-1:0]     imm;
		logic [CSR_ADDR_WIDTH-1:0] csr_addr;
	} inst_t;

	typedef struct packed {
		logic                  valid;
		inst_t                 inst;
		logic [DATA_WIDTH-1:0] rs1_data;
		logic [DATA_WIDTH-1:0] rs2_data;
		logic                  rs1_fwd_id;  // Operand was taken from EX while in ID.
		logic                  rs2_fwd_id;
	} id_ex_t;

	typedef struct packed {
		logic                      valid;
		logic [REG_ADDR_WIDTH-1:0] rd;
		logic                      write_reg;
		logic [DATA_WIDTH-1:0]     data;
	} ex_wb_t;

endpackage

/* regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rs1,
	input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rs2,
	output logic [core_pkg::DATA_WIDTH-1:0]     rs1_data,
	output logic [core_pkg::DATA_WIDTH-1:0]     rs2_data,
	input  logic                                we,
	input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rd,
	input  logic [core_pkg::DATA_WIDTH-1:0]     wd
);
	import core_pkg::*;

	logic [DATA_WIDTH-1:0] regs [1:NUM_REGS-1];  // x0 has no storage.

	// A write in flight is returned to the reader in the same cycle.
	function automatic logic [DATA_WIDTH-1:0] read_port(input logic [REG_ADDR_WIDTH-1:0] idx);
		if (idx == '0)
			return '0;
		if (we && (idx == rd))
			return wd;
		return regs[idx];
	endfunction

	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we && (rd != '0)) begin
			regs[rd] <= wd;
		end
	end

endmodule

/* forwarding_id.sv */
`timescale 1ns/1ps

module forwarding_id (
	input  logic [core_pkg::DATA_WIDTH-1:0]     rs1_data_id,
	input  logic [core_pkg::DATA_WIDTH-1:0]     rs2_data_id,
	input  logic [core_pkg::DATA_WIDTH-1:0]     alu_output_ex,
	input  logic [core_pkg::DATA_WIDTH-1:0]     csr_read_data_ex,
	input  logic [core_pkg::DATA_WIDTH-1:0]     imm_ex,
	input  logic                                csr_we_ex,
	input  logic                                lui_type_ex,
	input  logic                                write_reg_ex,
	input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rs1_id,
	input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rs2_id,
	input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rd_ex,
	output logic [core_pkg::DATA_WIDTH-1:0]     rs1_data_forward_id,
	output logic [core_pkg::DATA_WIDTH-1:0]     rs2_data_forward_id,
	output logic                                rs1_hit,
	output logic                                rs2_hit
);
	import core_pkg::*;

	logic rs1_match;
	logic rs2_match;
	logic kind_clash;

	// The kind of the EX instruction picks which of its values is the newest.
	function automatic logic [DATA_WIDTH-1:0] pick(
		input logic                  match,
		input logic                  csr_we,
		input logic                  lui_type,
		input logic [DATA_WIDTH-1:0] reg_value,
		input logic [DATA_WIDTH-1:0] alu_value,
		input logic [DATA_WIDTH-1:0] imm_value,
		input logic [DATA_WIDTH-1:0] csr_value
	);
		case ({match, csr_we, lui_type})
			3'b100:  return alu_value;
			3'b101:  return imm_value;
			3'b110:  return csr_value;
			default: return reg_value;  // No match, or lui and csr both set.
		endcase
	endfunction

	assign rs1_match  = write_reg_ex && (|rd_ex) && (rd_ex == rs1_id);
	assign rs2_match  = write_reg_ex && (|rd_ex) && (rd_ex == rs2_id);
	assign kind_clash = lui_type_ex && csr_we_ex;
	assign rs1_hit    = rs1_match && !kind_clash;
	assign rs2_hit    = rs2_match && !kind_clash;

	assign rs1_data_forward_id = pick(rs1_match, csr_we_ex, lui_type_ex, rs1_data_id,
		alu_output_ex, imm_ex, csr_read_data_ex);
	assign rs2_data_forward_id = pick(rs2_match, csr_we_ex, lui_type_ex, rs2_data_id,
		alu_output_ex, imm_ex, csr_read_data_ex);

endmodule

/* forwarding_ex.sv */
`timescale 1ns/1ps

module forwarding_ex (
	input  logic [core_pkg::DATA_WIDTH-1:0]     rs1_data_ex,
	input  logic [core_pkg::DATA_WIDTH-1:0]     rs2_data_ex,
	input  logic [core_pkg::DATA_WIDTH-1:0]     wb_data_wb,
	input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rs1_ex,
	input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rs2_ex,
	input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rd_wb,
	input  logic                                write_reg_wb,
	input  logic                                rs1_fwd_id,
	input  logic                                rs2_fwd_id,
	output logic [core_pkg::DATA_WIDTH-1:0]     rs1_data_forward,
	output logic [core_pkg::DATA_WIDTH-1:0]     rs2_data_forward
);

	logic wb_writes;
	logic rs1_take_wb;
	logic rs2_take_wb;

	assign wb_writes = write_reg_wb && (|rd_wb);

	// A value already taken from EX in ID is newer than anything in WB.
	assign rs1_take_wb = wb_writes && (rd_wb == rs1_ex) && !rs1_fwd_id;
	assign rs2_take_wb = wb_writes && (rd_wb == rs2_ex) && !rs2_fwd_id;

	assign rs1_data_forward = rs1_take_wb ? wb_data_wb : rs1_data_ex;
	assign rs2_data_forward = rs2_take_wb ? wb_data_wb : rs2_data_ex;

endmodule

/* csr_file.sv */
`timescale 1ns/1ps

module csr_file (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [core_pkg::CSR_ADDR_WIDTH-1:0] addr,
	output logic [core_pkg::DATA_WIDTH-1:0]     rdata,
	input  logic                                we,
	input  logic [core_pkg::DATA_WIDTH-1:0]     wdata
);
	import core_pkg::*;

	logic [DATA_WIDTH-1:0] csrs [NUM_CSRS];

	assign rdata = csrs[addr];  // Old value until the edge that writes it.

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_CSRS; i++)
				csrs[i] <= '0;
		end else if (we) begin
			csrs[addr] <= wdata;
		end
	end

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
	input  core_pkg::op_t                   op,
	input  logic [core_pkg::DATA_WIDTH-1:0] a,
	input  logic [core_pkg::DATA_WIDTH-1:0] b,
	output logic [core_pkg::DATA_WIDTH-1:0] y
);
	import core_pkg::*;

	always_comb begin
		case (op)
			OP_ADD: begin
				y = a + b;
			end
			OP_SUB: begin
				y = a - b;
			end
			OP_AND: begin
				y = a & b;
			end
			OP_OR: begin
				y = a | b;
			end
			OP_XOR: begin
				y = a ^ b;
			end
			default: begin
				y = '0;  // lui and csrrw take their result elsewhere.
			end
		endcase
	end

endmodule

/* operand_pipe.sv */
`timescale 1ns/1ps

module operand_pipe (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                issue_valid,
	input  core_pkg::inst_t                     issue,
	output logic                                wb_valid,
	output logic [core_pkg::REG_ADDR_WIDTH-1:0] wb_rd,
	output logic                                wb_write,
	output logic [core_pkg::DATA_WIDTH-1:0]     wb_data
);
	import core_pkg::*;

	id_ex_t id_ex;
	ex_wb_t ex_mem;
	ex_wb_t mem_wb;

	logic [DATA_WIDTH-1:0] rs1_data_id;
	logic [DATA_WIDTH-1:0] rs2_data_id;
	logic [DATA_WIDTH-1:0] rs1_data_fwd_id;
	logic [DATA_WIDTH-1:0] rs2_data_fwd_id;
	logic                  rs1_hit;
	logic                  rs2_hit;
	logic [DATA_WIDTH-1:0] rs1_data_ex;
	logic [DATA_WIDTH-1:0] rs2_data_ex;
	logic [DATA_WIDTH-1:0] alu_y;
	logic [DATA_WIDTH-1:0] csr_rdata;
	logic [DATA_WIDTH-1:0] ex_result;
	logic                  lui_type_ex;
	logic                  csr_we_ex;
	logic                  write_reg_ex;
	logic                  write_reg_wb;
	logic                  rf_we;

	// ****************************************
	// ID stage
	// ****************************************

	regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.rs1      (issue.rs1),
		.rs2      (issue.rs2),
		.rs1_data (rs1_data_id),
		.rs2_data (rs2_data_id),
		.we       (rf_we),
		.rd       (mem_wb.rd),
		.wd       (mem_wb.data)
	);

	forwarding_id u_forwarding_id (
		.rs1_data_id         (rs1_data_id),
		.rs2_data_id         (rs2_data_id),
		.alu_output_ex       (alu_y),
		.csr_read_data_ex    (csr_rdata),
		.imm_ex              (id_ex.inst.imm),
		.csr_we_ex           (csr_we_ex),
		.lui_type_ex         (lui_type_ex),
		.write_reg_ex        (write_reg_ex),
		.rs1_id              (issue.rs1),
		.rs2_id              (issue.rs2),
		.rd_ex               (id_ex.inst.rd),
		.rs1_data_forward_id (rs1_data_fwd_id),
		.rs2_data_forward_id (rs2_data_fwd_id),
		.rs1_hit             (rs1_hit),
		.rs2_hit             (rs2_hit)
	);

	always_ff @(posedge clk) begin
		if (rst || !issue_valid) begin
			id_ex <= '0;  // Bubble.
		end else begin
			id_ex <= '{valid: 1'b1, inst: issue, rs1_data: rs1_data_fwd_id,
				rs2_data: rs2_data_fwd_id, rs1_fwd_id: rs1_hit, rs2_fwd_id: rs2_hit};
		end
	end

	// ****************************************
	// EX stage
	// ****************************************

	assign write_reg_ex = id_ex.valid && id_ex.inst.write_reg;
	assign lui_type_ex  = id_ex.valid && (id_ex.inst.op == OP_LUI);
	assign csr_we_ex    = id_ex.valid && (id_ex.inst.op == OP_CSRRW);
	assign write_reg_wb = mem_wb.valid && mem_wb.write_reg;

	forwarding_ex u_forwarding_ex (
		.rs1_data_ex      (id_ex.rs1_data),
		.rs2_data_ex      (id_ex.rs2_data),
		.wb_data_wb       (mem_wb.data),
		.rs1_ex           (id_ex.inst.rs1),
		.rs2_ex           (id_ex.inst.rs2),
		.rd_wb            (mem_wb.rd),
		.write_reg_wb     (write_reg_wb),
		.rs1_fwd_id       (id_ex.rs1_fwd_id),
		.rs2_fwd_id       (id_ex.rs2_fwd_id),
		.rs1_data_forward (rs1_data_ex),
		.rs2_data_forward (rs2_data_ex)
	);

	alu u_alu (
		.op (id_ex.inst.op),
		.a  (rs1_data_ex),
		.b  (rs2_data_ex),
		.y  (alu_y)
	);

	csr_file u_csr_file (
		.clk   (clk),
		.rst   (rst),
		.addr  (id_ex.inst.csr_addr),
		.rdata (csr_rdata),
		.we    (csr_we_ex),
		.wdata (rs1_data_ex)
	);

	always_comb begin
		case (id_ex.inst.op)
			OP_LUI:   ex_result = id_ex.inst.imm;
			OP_CSRRW: ex_result = csr_rdata;
			default:  ex_result = alu_y;
		endcase
	end

	// ****************************************
	// MEM and WB stages
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem <= '0;
			mem_wb <= '0;
		end else begin
			ex_mem <= '{valid: id_ex.valid, rd: id_ex.inst.rd,
				write_reg: id_ex.inst.write_reg, data: ex_result};
			mem_wb <= ex_mem;  // No memory access in this core.
		end
	end

	assign rf_we = mem_wb.valid && mem_wb.write_reg && (|mem_wb.rd);

	assign wb_valid = mem_wb.valid;
	assign wb_rd    = mem_wb.rd;
	assign wb_write = mem_wb.write_reg;
	assign wb_data  = mem_wb.data;

endmodule

/* operand_pipe_asserts.sv */
`timescale 1ns/1ps

module operand_pipe_asserts (
	input logic                            clk,
	input logic                            rst,
	input logic                            wb_valid,
	input core_pkg::inst_t                 issue,
	input logic [core_pkg::DATA_WIDTH-1:0] rs1_data_id,
	input logic [core_pkg::DATA_WIDTH-1:0] rs2_data_id,
	input core_pkg::id_ex_t                id_ex,
	input logic [core_pkg::DATA_WIDTH-1:0] rs1_data_ex,
	input logic [core_pkg::DATA_WIDTH-1:0] rs2_data_ex
);

	int failures = 0;

	// ****************************************
	// Reset and x0
	// ****************************************

	reset_clears_wb: assert property (@(posedge clk) rst |=> !wb_valid)
		else begin
			failures++;
			$error("wb_valid is high in the cycle after reset");
		end

	x0_rs1_zero: assert property (@(posedge clk) disable iff (rst)
		(issue.rs1 == '0) |-> (rs1_data_id == '0))
		else begin
			failures++;
			$error("Register x0 read nonzero on port rs1");
		end

	x0_rs2_zero: assert property (@(posedge clk) disable iff (rst)
		(issue.rs2 == '0) |-> (rs2_data_id == '0))
		else begin
			failures++;
			$error("Register x0 read nonzero on port rs2");
		end

	// ****************************************
	// Forwarding priority
	// ****************************************

	id_fwd_kept_rs1: assert property (@(posedge clk) disable iff (rst)
		(id_ex.valid && id_ex.rs1_fwd_id) |-> (rs1_data_ex == id_ex.rs1_data))
		else begin
			failures++;
			$error("WB bypass replaced an rs1 value forwarded in ID");
		end

	id_fwd_kept_rs2: assert property (@(posedge clk) disable iff (rst)
		(id_ex.valid && id_ex.rs2_fwd_id) |-> (rs2_data_ex == id_ex.rs2_data))
		else begin
			failures++;
			$error("WB bypass replaced an rs2 value forwarded in ID");
		end

endmodule

/* tb_operand_pipe.sv */
`timescale 1ns/1ps

module tb_operand_pipe;
	import core_pkg::*;

	localparam int SEED           = 18100;
	localparam int RANDOM_COUNT   = 500;
	localparam int TIMEOUT_CYCLES = 2000;  // Directed tests ~100 cycles, random stream ~700.

	logic                      clk;
	logic                      rst;
	logic                      issue_valid;
	inst_t                     issue;
	logic                      wb_valid;
	logic [REG_ADDR_WIDTH-1:0] wb_rd;
	logic                      wb_write;
	logic [DATA_WIDTH-1:0]     wb_data;

	logic [DATA_WIDTH-1:0] model_regs [NUM_REGS];
	logic [DATA_WIDTH-1:0] model_csrs [NUM_CSRS];
	ex_wb_t                expected_q [$];  // One entry per issue slot, bubbles included.
	int                    errors;
	int                    checks;
	int                    cycles;

	operand_pipe u_operand_pipe (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue       (issue),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_write    (wb_write),
		.wb_data     (wb_data)
	);

	bind operand_pipe operand_pipe_asserts u_operand_pipe_asserts (
		.clk         (clk),
		.rst         (rst),
		.wb_valid    (wb_valid),
		.issue       (issue),
		.rs1_data_id (rs1_data_id),
		.rs2_data_id (rs2_data_id),
		.id_ex       (id_ex),
		.rs1_data_ex (rs1_data_ex),
		.rs2_data_ex (rs2_data_ex)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ****************************************
	// Checking and reference model
	// ****************************************

	task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] got,
		input logic [DATA_WIDTH-1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// Program order at issue time, so every operand is simply the latest architectural value.
	task automatic model_issue(input inst_t inst);
		logic [DATA_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] b;
		logic [DATA_WIDTH-1:0] result;
		ex_wb_t                rec;
		a = model_regs[inst.rs1];
		b = model_regs[inst.rs2];
		case (inst.op)
			OP_ADD:  result = a + b;
			OP_SUB:  result = a - b;
			OP_AND:  result = a & b;
			OP_OR:   result = a | b;
			OP_XOR:  result = a ^ b;
			OP_LUI:  result = inst.imm;
			default: begin
				result = model_csrs[inst.csr_addr];  // csrrw returns the old value.
				model_csrs[inst.csr_addr] = a;
			end
		endcase
		if (inst.write_reg && (inst.rd != '0))
			model_regs[inst.rd] = result;
		rec.valid     = 1'b1;
		rec.rd        = inst.rd;
		rec.write_reg = inst.write_reg;
		rec.data      = result;
		expected_q.push_back(rec);
	endtask

	// Checks the writeback due in this cycle, then drives the next issue slot.
	task automatic step(input logic valid, input inst_t inst);
		ex_wb_t due;
		@(negedge clk);
		due = expected_q.pop_front();
		check_value("wb_valid", 32'(wb_valid), 32'(due.valid));
		if (due.valid) begin
			check_value("wb_rd", 32'(wb_rd), 32'(due.rd));
			check_value("wb_write", 32'(wb_write), 32'(due.write_reg));
			check_value("wb_data", wb_data, due.data);
		end
		issue_valid = valid;
		issue       = inst;
		if (valid)
			model_issue(inst);
		else
			expected_q.push_back('0);
	endtask

	function automatic inst_t make_inst(input op_t op, input int rd, input int rs1, input int rs2,
		input logic [DATA_WIDTH-1:0] imm, input int csr, input logic write_reg);
		inst_t inst;
		inst.op        = op;
		inst.rd        = REG_ADDR_WIDTH'(rd);
		inst.rs1       = REG_ADDR_WIDTH'(rs1);
		inst.rs2       = REG_ADDR_WIDTH'(rs2);
		inst.imm       = imm;
		inst.csr_addr  = CSR_ADDR_WIDTH'(csr);
		inst.write_reg = write_reg;
		return inst;
	endfunction

	function automatic inst_t random_inst();
		inst_t      inst;
		logic [2:0] op_bits;
		op_bits        = 3'($urandom_range(6, 0));
		inst.op        = op_t'(op_bits);
		inst.rd        = REG_ADDR_WIDTH'($urandom_range(7, 0));
		inst.rs1       = REG_ADDR_WIDTH'($urandom_range(7, 0));
		inst.rs2       = REG_ADDR_WIDTH'($urandom_range(7, 0));
		inst.imm       = $urandom() & 32'hffff_f000;  // A lui immediate has a clear low 12 bits.
		inst.csr_addr  = CSR_ADDR_WIDTH'($urandom_range(3, 0));
		inst.write_reg = ($urandom_range(7, 0) != 0);
		return inst;
	endfunction

	task automatic alu_op(input op_t op, input int rd, input int rs1, input int rs2);
		step(1'b1, make_inst(op, rd, rs1, rs2, '0, 0, 1'b1));
	endtask

	task automatic lui_op(input int rd, input logic [DATA_WIDTH-1:0] imm);
		step(1'b1, make_inst(OP_LUI, rd, 0, 0, imm, 0, 1'b1));
	endtask

	task automatic csr_op(input int rd, input int rs1, input int csr);
		step(1'b1, make_inst(OP_CSRRW, rd, rs1, 0, '0, csr, 1'b1));
	endtask

	task automatic bubble();
		step(1'b0, '0);
	endtask

	// ****************************************
	// Directed and random tests
	// ****************************************

	task automatic test_reset_bubbles();
		repeat (5) bubble();
		alu_op(OP_ADD, 1, 0, 0);
		repeat (4) bubble();
	endtask

	task automatic test_alu_chain();
		lui_op(1, 32'h1234_5000);
		lui_op(2, 32'h0f0f_3000);
		alu_op(OP_ADD, 3, 1, 2);
		alu_op(OP_SUB, 4, 3, 1);
		alu_op(OP_AND, 5, 4, 3);
		alu_op(OP_OR, 6, 5, 1);
		alu_op(OP_XOR, 7, 6, 3);
		alu_op(OP_ADD, 7, 7, 1);
	endtask

	task automatic test_distances();
		for (int d = 1; d <= 4; d++) begin
			lui_op(11, 32'(d) << 12);
			alu_op(OP_ADD, 11, 11, 1);  // Newer producer of x11.
			for (int f = 1; f < d; f++)
				alu_op(OP_XOR, 12, 13, 2);
			alu_op(OP_XOR, 14, 11, 1);
		end
	endtask

	task automatic test_lui_csr();
		lui_op(1, 32'habcd_e000);
		csr_op(2, 1, 1);
		alu_op(OP_ADD, 3, 2, 1);     // Old CSR value at distance 1.
		csr_op(4, 3, 1);             // Sees the value the previous csrrw wrote.
		alu_op(OP_ADD, 9, 4, 1);
		lui_op(5, 32'h0005_5000);
		alu_op(OP_SUB, 6, 5, 1);
		alu_op(OP_ADD, 7, 5, 4);
		csr_op(8, 7, 1);
		alu_op(OP_AND, 9, 0, 0);
		alu_op(OP_XOR, 10, 8, 7);
		csr_op(11, 6, 1);
	endtask

	task automatic test_x0_no_write();
		lui_op(13, 32'h7777_7000);
		lui_op(0, 32'hffff_f000);
		alu_op(OP_ADD, 14, 0, 13);
		alu_op(OP_ADD, 15, 0, 0);
		step(1'b1, make_inst(OP_LUI, 13, 0, 0, 32'h1111_1000, 0, 1'b0));
		alu_op(OP_OR, 16, 13, 0);
		alu_op(OP_OR, 21, 13, 0);
		alu_op(OP_OR, 17, 13, 0);
		csr_op(0, 13, 1);
		alu_op(OP_XOR, 18, 0, 13);
		repeat (2) bubble();
		alu_op(OP_ADD, 19, 0, 13);
		csr_op(20, 0, 1);
	endtask

	task automatic test_random_stream();
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			while ($urandom_range(3, 0) == 0)
				bubble();
			step(1'b1, random_inst());
		end
	endtask

	initial begin
		errors      = 0;
		checks      = 0;
		cycles      = 0;
		rst         = 1'b1;
		issue_valid = 1'b0;
		issue       = '0;
		void'($urandom(SEED));
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;
		for (int i = 0; i < NUM_CSRS; i++)
			model_csrs[i] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (3) expected_q.push_back('0);  // Stages cleared by reset.
		test_reset_bubbles();
		test_alu_chain();
		test_distances();
		test_lui_csr();
		test_x0_no_write();
		test_random_stream();
		repeat (3) bubble();
		$display("Tests done: %0d checks, %0d errors, %0d assertion failures", checks, errors,
			u_operand_pipe.u_operand_pipe_asserts.failures);
		if ((errors == 0) && (u_operand_pipe.u_operand_pipe_asserts.failures == 0)) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* all.f */
core_pkg.sv
regfile.sv
forwarding_id.sv
forwarding_ex.sv
csr_file.sv
alu.sv
operand_pipe.sv
operand_pipe_asserts.sv
tb_operand_pipe.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module tb_operand_pipe -f all.f -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "PASS: all tests" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
